// ==== flist.f ====
common/shooter_pkg.sv
hw/ship_control.sv
en_bullet_pool/en_bullet_pool.sv
hw/detect_collision.sv
hw/shooter_core.sv
dv/tb_shooter_core.sv

// ==== dv/tb_shooter_core.sv ====
// Testbench for the shooter play-field core
// Reference model, per-cycle assertions, directed frame sequences

`timescale 1ns/10ps
`default_nettype none

module tb_shooter_core;
  import shooter_pkg::*;

  localparam int N_BULLETS       = 5;
  localparam int BULLET_SPEED    = 8;
  localparam int SHIP_STEP       = 4;
  localparam int CLK_PERIOD      = 100;
  localparam int FRAME_CYCLES    = 8;
  localparam int WATCHDOG_FRAMES = 700;
  localparam int X_MIN           = int'(HALF_SHIP_WIDTH);
  localparam int X_MAX           = int'(SCREEN_W) - 1 - int'(HALF_SHIP_WIDTH);
  localparam int Y_TOP           = int'(Y_SHIP);
  localparam int Y_BOTTOM        = int'(Y_SHIP) + int'(SHIP_HEIGHT) - 1;

  logic                 pclk;
  logic                 rst;
  logic                 frame_tick;
  logic                 btn_left;
  logic                 btn_right;
  logic                 enemy_fire;
  coord_t               enemy_x;
  logic                 restart;
  coord_t               ship_x;
  coord_t               bullet_x [N_BULLETS];
  coord_t               bullet_y [N_BULLETS];
  logic [N_BULLETS-1:0] bullet_active;
  logic                 is_ship_dead;

  // Reference model state
  int                   m_ship_x;
  int                   m_bx [N_BULLETS];
  int                   m_by [N_BULLETS];
  logic [N_BULLETS-1:0] m_active;
  bit                   m_pend;
  int                   m_pend_x;
  bit                   m_dead;

  int    errors;
  int    errors_at_start;
  int    tests_passed;
  int    tests_failed;
  string test_name;

  shooter_core uut (
    .pclk          (pclk),
    .rst           (rst),
    .frame_tick    (frame_tick),
    .btn_left      (btn_left),
    .btn_right     (btn_right),
    .enemy_fire    (enemy_fire),
    .enemy_x       (enemy_x),
    .restart       (restart),
    .ship_x        (ship_x),
    .bullet_x      (bullet_x),
    .bullet_y      (bullet_y),
    .bullet_active (bullet_active),
    .is_ship_dead  (is_ship_dead)
  );

  initial pclk = 1'b0;
  always #(CLK_PERIOD / 2) pclk = ~pclk;

  // Ship box test, signed so the left edge may go below zero
  function automatic bit in_ship_box(int sx, int bx, int by);
    return (bx >= sx - X_MIN) && (bx <= sx + X_MIN) && (by >= Y_TOP) && (by <= Y_BOTTOM);
  endfunction

  always @(posedge pclk) begin : ship_model
    int nx;
    if (rst || restart) begin
      m_ship_x <= int'(SHIP_START_X);
    end else if (frame_tick && !m_dead) begin
      nx = m_ship_x;
      if (btn_left && !btn_right) begin
        nx = m_ship_x - SHIP_STEP;
      end else if (btn_right && !btn_left) begin
        nx = m_ship_x + SHIP_STEP;
      end
      // Stop at the screen edges
      if (nx < X_MIN) begin
        nx = X_MIN;
      end
      if (nx > X_MAX) begin
        nx = X_MAX;
      end
      m_ship_x <= nx;
    end
  end

  always @(posedge pclk) begin : pool_model
    int free_slot;
    int ny;
    if (rst || restart) begin
      m_pend   <= 1'b0;
      m_active <= '0;
    end else begin
      if (frame_tick) begin
        // Lowest slot free before this tick
        free_slot = -1;
        for (int i = 0; i < N_BULLETS; i++) begin
          if (!m_active[i] && free_slot < 0) begin
            free_slot = i;
          end
        end
        for (int i = 0; i < N_BULLETS; i++) begin
          if (m_active[i]) begin
            ny = m_by[i] + BULLET_SPEED;
            if (ny > int'(SCREEN_H) - 1) begin
              m_active[i] <= 1'b0;
            end else begin
              m_by[i] <= ny;
            end
          end
        end
        if (m_pend && free_slot >= 0) begin
          m_active[free_slot] <= 1'b1;
          m_bx[free_slot]     <= m_pend_x;
          m_by[free_slot]     <= int'(SPAWN_Y);
        end
        m_pend <= enemy_fire;
      end else if (enemy_fire) begin
        m_pend <= 1'b1;
      end
      if (enemy_fire) begin
        m_pend_x <= int'(enemy_x);
      end
    end
  end

  always @(posedge pclk) begin : dead_model
    bit any_hit;
    any_hit = 1'b0;
    for (int i = 0; i < N_BULLETS; i++) begin
      if (m_active[i] && in_ship_box(m_ship_x, m_bx[i], m_by[i])) begin
        any_hit = 1'b1;
      end
    end
    if (rst || restart) begin
      m_dead <= 1'b0;
    end else if (any_hit) begin
      m_dead <= 1'b1;
    end
  end

  task automatic report_mismatch(string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    errors++;
  endtask

  task automatic expect_equal(string what, int got, int exp);
    assert (got == exp) else begin
      report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
    end
  endtask

  // Model against DUT ports, sampled mid-cycle
  always @(negedge pclk) begin
    if (!rst) begin
      assert (int'(ship_x) == m_ship_x) else begin
        report_mismatch($sformatf("ship_x %0d, model %0d", ship_x, m_ship_x));
      end
      assert (bullet_active == m_active) else begin
        report_mismatch($sformatf("bullet_active %b, model %b", bullet_active, m_active));
      end
      for (int i = 0; i < N_BULLETS; i++) begin
        if (m_active[i]) begin
          assert (int'(bullet_x[i]) == m_bx[i] && int'(bullet_y[i]) == m_by[i]) else begin
            report_mismatch($sformatf("slot %0d at (%0d,%0d), model (%0d,%0d)",
                                      i, bullet_x[i], bullet_y[i], m_bx[i], m_by[i]));
          end
        end
      end
      assert (is_ship_dead == m_dead) else begin
        report_mismatch($sformatf("is_ship_dead %b, model %b", is_ship_dead, m_dead));
      end
    end
  end

  task automatic begin_test(string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("Test %s: done, no errors", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: done, %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic set_buttons(bit left, bit right);
    btn_left  = left;
    btn_right = right;
  endtask

  // One frame of 8 cycles, optional fire strobe after the tick
  // Starts and ends 10 ns after a rising edge
  task automatic step_frame(bit fire, coord_t fx);
    frame_tick = 1'b1;
    @(posedge pclk);
    #10;
    frame_tick = 1'b0;
    enemy_fire = fire;
    enemy_x    = fx;
    @(posedge pclk);
    #10;
    enemy_fire = 1'b0;
    repeat (FRAME_CYCLES - 2) @(posedge pclk);
    #10;
  endtask

  initial begin
    #(WATCHDOG_FRAMES * FRAME_CYCLES * CLK_PERIOD);
    $display("Watchdog: the run timed out after %0d frames", WATCHDOG_FRAMES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int     cols [6];
    int     frames;
    coord_t x_miss;
    coord_t x_hit;
    void'($urandom(71));
    rst        = 1'b1;
    frame_tick = 1'b0;
    btn_left   = 1'b0;
    btn_right  = 1'b0;
    enemy_fire = 1'b0;
    enemy_x    = '0;
    restart    = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (4) @(posedge pclk);
    #10;
    rst = 1'b0;

    begin_test("1 reset state");
    expect_equal("ship_x after reset", int'(ship_x), int'(SHIP_START_X));
    expect_equal("bullet_active after reset", int'(bullet_active), 0);
    expect_equal("is_ship_dead after reset", int'(is_ship_dead), 0);
    end_test();

    begin_test("2 ship motion");
    set_buttons(1'b1, 1'b1);
    repeat (4) step_frame(1'b0, '0);
    expect_equal("ship_x with both buttons", int'(ship_x), int'(SHIP_START_X));
    set_buttons(1'b0, 1'b1);
    repeat (200) step_frame(1'b0, '0);
    expect_equal("ship_x at right edge", int'(ship_x), X_MAX);
    set_buttons(1'b1, 1'b0);
    repeat (250) step_frame(1'b0, '0);
    expect_equal("ship_x at left edge", int'(ship_x), X_MIN);
    set_buttons(1'b0, 1'b0);
    end_test();

    begin_test("3 bullet pool");
    // Columns kept clear of the ship parked at the left edge
    for (int k = 0; k < 6; k++) begin
      cols[k] = 100 + int'($urandom % 900);
    end
    for (int k = 0; k < 6; k++) begin
      step_frame(1'b1, coord_t'(cols[k]));
    end
    // This tick finds the pool full and drops the sixth request
    step_frame(1'b0, '0);
    expect_equal("bullet_active with full pool", int'(bullet_active), 31);
    for (int k = 0; k < N_BULLETS; k++) begin
      expect_equal($sformatf("slot %0d x", k), int'(bullet_x[k]), cols[k]);
      expect_equal($sformatf("slot %0d y", k), int'(bullet_y[k]),
                   int'(SPAWN_Y) + BULLET_SPEED * (5 - k));
    end
    step_frame(1'b0, '0);
    expect_equal("bullet_active after dropped request", int'(bullet_active), 31);
    frames = 0;
    while (bullet_active != '0 && frames < 100) begin
      step_frame(1'b0, '0);
      frames++;
    end
    if (bullet_active != '0) begin
      $display("Bullets were still active 100 frames after the pool filled");
      errors++;
    end
    end_test();

    begin_test("4 collision");
    x_miss = coord_t'(X_MIN + X_MIN + 1);
    x_hit  = coord_t'(0);
    step_frame(1'b1, x_miss);
    repeat (5) step_frame(1'b0, '0);
    step_frame(1'b1, x_hit);
    // Hit bullet spawns here, then falls to the row above the band
    step_frame(1'b0, '0);
    repeat (76) step_frame(1'b0, '0);
    expect_equal("is_ship_dead after near miss", int'(is_ship_dead), 0);
    frame_tick = 1'b1;
    @(posedge pclk);
    #10;
    frame_tick = 1'b0;
    expect_equal("is_ship_dead as bullet enters band", int'(is_ship_dead), 0);
    @(posedge pclk);
    #10;
    expect_equal("is_ship_dead one cycle later", int'(is_ship_dead), 1);
    repeat (FRAME_CYCLES - 2) @(posedge pclk);
    #10;
    end_test();

    begin_test("5 dead ship and restart");
    set_buttons(1'b0, 1'b1);
    repeat (2) step_frame(1'b0, '0);
    set_buttons(1'($urandom % 2), 1'($urandom % 2));
    repeat (2) step_frame(1'b0, '0);
    expect_equal("ship_x while dead", int'(ship_x), X_MIN);
    set_buttons(1'b0, 1'b0);
    // Pending request just before restart must be lost
    enemy_fire = 1'b1;
    enemy_x    = coord_t'(100 + int'($urandom % 900));
    @(posedge pclk);
    #10;
    enemy_fire = 1'b0;
    restart    = 1'b1;
    @(posedge pclk);
    #10;
    restart = 1'b0;
    expect_equal("is_ship_dead after restart", int'(is_ship_dead), 0);
    expect_equal("ship_x after restart", int'(ship_x), int'(SHIP_START_X));
    expect_equal("bullet_active after restart", int'(bullet_active), 0);
    repeat (FRAME_CYCLES - 2) @(posedge pclk);
    #10;
    repeat (2) step_frame(1'b0, '0);
    expect_equal("bullet_active after ticks", int'(bullet_active), 0);
    end_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/shooter_core.sv ====
// Play-field top level of the shooter
// Ship control, enemy bullet pool and collision test

`timescale 1ns/10ps
`default_nettype none

module shooter_core
  import shooter_pkg::*;
#(
  parameter int N_BULLETS    = 5,
  parameter int BULLET_SPEED = 8,
  parameter int SHIP_STEP    = 4
) (
  input  logic                 pclk,
  input  logic                 rst,
  input  logic                 frame_tick,
  input  logic                 btn_left,
  input  logic                 btn_right,
  input  logic                 enemy_fire,
  input  coord_t               enemy_x,
  input  logic                 restart,
  output coord_t               ship_x,
  output coord_t               bullet_x [N_BULLETS],
  output coord_t               bullet_y [N_BULLETS],
  output logic [N_BULLETS-1:0] bullet_active,
  output logic                 is_ship_dead
);

  // Dead flag also feeds back to freeze the ship
  ship_control #(
    .SHIP_STEP    (SHIP_STEP)
  ) u_ship_control (
    .pclk         (pclk),
    .rst          (rst),
    .frame_tick   (frame_tick),
    .restart      (restart),
    .btn_left     (btn_left),
    .btn_right    (btn_right),
    .is_ship_dead (is_ship_dead),
    .ship_x       (ship_x)
  );

  en_bullet_pool #(
    .N_BULLETS     (N_BULLETS),
    .BULLET_SPEED  (BULLET_SPEED)
  ) u_en_bullet_pool (
    .pclk          (pclk),
    .rst           (rst),
    .frame_tick    (frame_tick),
    .restart       (restart),
    .enemy_fire    (enemy_fire),
    .enemy_x       (enemy_x),
    .bullet_x      (bullet_x),
    .bullet_y      (bullet_y),
    .bullet_active (bullet_active)
  );

  detect_collision #(
    .N_BULLETS     (N_BULLETS)
  ) u_detect_collision (
    .pclk          (pclk),
    .rst           (rst),
    .restart       (restart),
    .ship_x        (ship_x),
    .bullet_x      (bullet_x),
    .bullet_y      (bullet_y),
    .bullet_active (bullet_active),
    .is_ship_dead  (is_ship_dead)
  );

endmodule

`default_nettype wire

// ==== hw/detect_collision.sv ====
// Ship against enemy bullet hit test
// Any active bullet inside the ship box sets a sticky dead flag

`timescale 1ns/10ps
`default_nettype none

module detect_collision
  import shooter_pkg::*;
#(
  parameter int N_BULLETS = 5
) (
  input  logic                 pclk,
  input  logic                 rst,
  input  logic                 restart,
  input  coord_t               ship_x,
  input  coord_t               bullet_x [N_BULLETS],
  input  coord_t               bullet_y [N_BULLETS],
  input  logic [N_BULLETS-1:0] bullet_active,
  output logic                 is_ship_dead
);

  // Full ship height, not only the top row
  localparam coord_t Y_TOP    = Y_SHIP;
  localparam coord_t Y_BOTTOM = Y_SHIP + SHIP_HEIGHT - 11'd1;

  logic [N_BULLETS-1:0] hit;
  logic [11:0]          ship_reach;
  logic [11:0]          bx_reach [N_BULLETS];
  logic                 in_x;
  logic                 in_y;

  // Right edge of the ship box, one bit wider
  assign ship_reach = {1'b0, ship_x} + {1'b0, HALF_SHIP_WIDTH};

  // Left side tested as bullet_x + half >= ship_x to avoid underflow
  always_comb begin
    in_x = 1'b0;
    in_y = 1'b0;
    for (int i = 0; i < N_BULLETS; i++) begin
      bx_reach[i] = {1'b0, bullet_x[i]} + {1'b0, HALF_SHIP_WIDTH};
      in_x = (bx_reach[i] >= {1'b0, ship_x}) &&
             ({1'b0, bullet_x[i]} <= ship_reach);
      in_y = (bullet_y[i] >= Y_TOP) && (bullet_y[i] <= Y_BOTTOM);
      hit[i] = bullet_active[i] && in_x && in_y;
    end
  end

  // Sticky until reset or restart
  always_ff @(posedge pclk) begin
    if (rst || restart) begin
      is_ship_dead <= 1'b0;
    end else if (|hit) begin
      is_ship_dead <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== en_bullet_pool/en_bullet_pool.sv ====
// Enemy bullet slot pool
// Pending fire request, per-frame fall, retire at screen bottom,
// lowest free slot allocation

`timescale 1ns/10ps
`default_nettype none

module en_bullet_pool
  import shooter_pkg::*;
#(
  parameter int N_BULLETS    = 5,
  parameter int BULLET_SPEED = 8
) (
  input  logic                 pclk,
  input  logic                 rst,
  input  logic                 frame_tick,
  input  logic                 restart,
  input  logic                 enemy_fire,
  input  coord_t               enemy_x,
  output coord_t               bullet_x [N_BULLETS],
  output coord_t               bullet_y [N_BULLETS],
  output logic [N_BULLETS-1:0] bullet_active
);

  localparam coord_t SPEED = coord_t'(BULLET_SPEED);

  // One extra bit so the stepped row never wraps
  localparam logic [11:0] Y_LAST = {1'b0, SCREEN_H} - 12'd1;

  // Fire request waiting for the next frame
  logic   pending_valid;
  coord_t pending_x;

  logic [N_BULLETS-1:0] free_onehot;
  logic                 slot_found;
  logic [N_BULLETS-1:0] spawn;
  logic [N_BULLETS-1:0] leaves;
  logic [11:0]          y_step [N_BULLETS];

  // Lowest inactive slot, one-hot
  // Uses the active bits before this frame's retirements
  always_comb begin
    free_onehot = '0;
    slot_found  = 1'b0;
    for (int i = 0; i < N_BULLETS; i++) begin
      if (!bullet_active[i] && !slot_found) begin
        free_onehot[i] = 1'b1;
        slot_found     = 1'b1;
      end
    end
  end

  // With no free slot the request simply gets no spawn bit
  assign spawn = pending_valid ? free_onehot : '0;

  // Next row of every slot and whether it drops off the bottom
  always_comb begin
    for (int i = 0; i < N_BULLETS; i++) begin
      y_step[i] = {1'b0, bullet_y[i]} + {1'b0, SPEED};
      leaves[i] = bullet_active[i] && (y_step[i] > Y_LAST);
    end
  end

  // Control state
  always_ff @(posedge pclk) begin
    if (rst || restart) begin
      pending_valid <= 1'b0;
      bullet_active <= '0;
    end else begin
      if (frame_tick) begin
        // The tick consumes the old request, a fire in this cycle waits
        pending_valid <= enemy_fire;
        for (int i = 0; i < N_BULLETS; i++) begin
          if (leaves[i]) begin
            bullet_active[i] <= 1'b0;
          end else if (spawn[i]) begin
            bullet_active[i] <= 1'b1;
          end
        end
      end else if (enemy_fire) begin
        pending_valid <= 1'b1;
      end
    end
  end

  // Column of the latest fire strobe, later strobes overwrite it
  always_ff @(posedge pclk) begin
    if (enemy_fire) begin
      pending_x <= enemy_x;
    end
  end

  // Slot positions
  always_ff @(posedge pclk) begin
    if (frame_tick) begin
      for (int i = 0; i < N_BULLETS; i++) begin
        if (bullet_active[i]) begin
          // Falls one step, a retired slot keeps a stale row
          bullet_y[i] <= y_step[i][10:0];
        end else if (spawn[i]) begin
          bullet_x[i] <= pending_x;
          bullet_y[i] <= SPAWN_Y;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/ship_control.sv ====
// Ship motion from left/right button levels
// One clamped step per frame, frozen once the ship is dead

`timescale 1ns/10ps
`default_nettype none

module ship_control
  import shooter_pkg::*;
#(
  parameter int SHIP_STEP = 4
) (
  input  logic   pclk,
  input  logic   rst,
  input  logic   frame_tick,
  input  logic   restart,
  input  logic   btn_left,
  input  logic   btn_right,
  input  logic   is_ship_dead,
  output coord_t ship_x
);

  localparam coord_t STEP  = coord_t'(SHIP_STEP);

  // Centre limits that keep the whole ship on screen
  localparam coord_t X_MIN = HALF_SHIP_WIDTH;
  localparam coord_t X_MAX = SCREEN_W - 11'd1 - HALF_SHIP_WIDTH;

  logic   move_left;
  logic   move_right;
  coord_t x_left;
  coord_t x_right;
  coord_t x_next;

  // Opposing buttons cancel out
  assign move_left  = btn_left & ~btn_right;
  assign move_right = btn_right & ~btn_left;

  // Candidate positions, clamped before the step could cross a limit
  always_comb begin
    if (ship_x < X_MIN + STEP) begin
      x_left = X_MIN;
    end else begin
      x_left = ship_x - STEP;
    end

    if (ship_x > X_MAX - STEP) begin
      x_right = X_MAX;
    end else begin
      x_right = ship_x + STEP;
    end
  end

  always_comb begin
    if (move_left) begin
      x_next = x_left;
    end else if (move_right) begin
      x_next = x_right;
    end else begin
      x_next = ship_x;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst || restart) begin
      ship_x <= SHIP_START_X;
    end else if (frame_tick && !is_ship_dead) begin
      ship_x <= x_next;
    end
  end

endmodule

`default_nettype wire

// ==== common/shooter_pkg.sv ====
// Shared types and play-field geometry for the shooter subsystem
// Coordinate type, screen size, ship box and bullet spawn row

`default_nettype none

package shooter_pkg;

  // Pixel coordinate, wide enough for both screen axes
  typedef logic [10:0] coord_t;

  // Play-field size in pixels
  localparam coord_t SCREEN_W = 11'd1024;
  localparam coord_t SCREEN_H = 11'd768;

  // Ship box
  // Top row of the ship band
  localparam coord_t Y_SHIP = 11'd680;

  // Rows covered by the ship, counted from Y_SHIP
  localparam coord_t SHIP_HEIGHT = 11'd32;

  // Reach either side of the ship centre, inclusive
  localparam coord_t HALF_SHIP_WIDTH = 11'd24;

  // Centre column after reset or restart
  localparam coord_t SHIP_START_X = 11'd512;

  // Enemy bullets
  // First row of a freshly spawned bullet, just below the enemy line
  localparam coord_t SPAWN_Y = 11'd64;

endpackage

`default_nettype wire
